// File: compile.f
+incdir+design
design/memctl_pkg.sv
design/cdc_fifo.sv
design/ahb_front.sv
design/ui_issuer.sv
design/mig_bridge_top.sv
dv/tb_clkgen.sv
dv/ui_mem_model.sv
dv/tb_top.sv

// File: Bender.yml
package:
  name: mig_bridge

export_include_dirs:
  - design

sources:
  - design/memctl_pkg.sv
  - design/cdc_fifo.sv
  - design/ahb_front.sv
  - design/ui_issuer.sv
  - design/mig_bridge_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/tb_clkgen.sv
      - dv/ui_mem_model.sv
      - dv/tb_top.sv

// File: dv/tb_top.sv
// Testbench for the AHB-Lite to DDR UI bridge
// Runs single AHB transfers against the behavioral controller model
// Concurrent assertions check read data, UI write beats, HRESP and sys_reset

`timescale 1ns/100ps
`default_nettype none

module tb_top import memctl_pkg::*; ();

  localparam int LIMIT     = 400;
  localparam int SEED      = 9666;
  localparam int DRIVE_DLY = 2;

  logic       hclk, ui_clk, reset;
  logic       hsel, hwrite, hreadyout, hresp;
  addr_t      haddr;
  logic [1:0] htrans;
  data_t      hwdata, hrdata;
  mask_t      hwstrb;
  logic       ui_rst, calib, sys_reset;
  addr_t      app_addr;
  ui_cmd_e    app_cmd;
  logic       app_en, app_rdy, app_wdf_wren, app_wdf_end, app_wdf_rdy, app_rd_data_valid;
  data_t      app_wdf_data, app_rd_data;
  mask_t      app_wdf_mask;

  // Reference memory and the bus strobe of every write in issue order
  data_t       ref_mem [256];
  mask_t       strobe_log [256];
  logic [7:0]  wr_cnt, wdf_cnt;
  data_t       exp_rdata;
  string       test_name;
  logic [31:0] rand_state;
  // AHB data phase tracking
  logic        dphase_q, dwrite_q;

  tb_clkgen #(.PERIOD_NS(40.0)) u_hclk_gen (.clk_o (hclk));
  tb_clkgen #(.PERIOD_NS(30.0)) u_ui_clk_gen (.clk_o (ui_clk));

  // HREADY loops back from HREADYOUT with a single slave
  mig_bridge_top dut (
    .hclk_i (hclk), .reset_i (reset), .hsel_i (hsel), .haddr_i (haddr),
    .htrans_i (htrans), .hwrite_i (hwrite), .hready_i (hreadyout), .hwdata_i (hwdata),
    .hwstrb_i (hwstrb), .hrdata_o (hrdata), .hreadyout_o (hreadyout), .hresp_o (hresp),
    .ui_clk_i (ui_clk), .ui_clk_sync_rst_i (ui_rst), .init_calib_complete_i (calib),
    .sys_reset_o (sys_reset),
    .app_addr_o (app_addr), .app_cmd_o (app_cmd), .app_en_o (app_en), .app_rdy_i (app_rdy),
    .app_wdf_data_o (app_wdf_data), .app_wdf_mask_o (app_wdf_mask),
    .app_wdf_wren_o (app_wdf_wren), .app_wdf_end_o (app_wdf_end), .app_wdf_rdy_i (app_wdf_rdy),
    .app_rd_data_i (app_rd_data), .app_rd_data_valid_i (app_rd_data_valid)
  );

  ui_mem_model #(.SEED(SEED)) u_mem (
    .ui_clk_i (ui_clk), .sys_rst_i (sys_reset), .ui_clk_sync_rst_o (ui_rst),
    .init_calib_complete_o (calib),
    .app_addr_i (app_addr), .app_cmd_i (app_cmd), .app_en_i (app_en), .app_rdy_o (app_rdy),
    .app_wdf_data_i (app_wdf_data), .app_wdf_mask_i (app_wdf_mask),
    .app_wdf_wren_i (app_wdf_wren), .app_wdf_rdy_o (app_wdf_rdy),
    .app_rd_data_o (app_rd_data), .app_rd_data_valid_o (app_rd_data_valid)
  );

  ////////////////////
  // Helpers
  function automatic logic [31:0] next_rand();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 17);
    rand_state = rand_state ^ (rand_state << 5);
    return rand_state;
  endfunction

  // Strobe bit set takes the new byte
  function automatic data_t merge_strobe(input data_t old_w, input data_t new_w,
                                         input mask_t strb);
    data_t r;
    r = old_w;
    for (int b = 0; b < 8; b++) begin
      if (strb[b])
        r[8*b +: 8] = new_w[8*b +: 8];
    end
    return r;
  endfunction

  function automatic data_t fill_word(input logic [7:0] a);
    return {~a, a, 16'hc35a, a, ~a, 16'h5ac3};
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "testbench stopped");
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    abort_run($sformatf("MISMATCH %s %s expected %h actual %h",
                        test_name, what, exp_val, act_val));
  endtask

  // Returns just after the edge that ends the current phase
  task automatic wait_ready();
    int n;
    n = 0;
    @(negedge hclk);
    while (!hreadyout) begin
      n++;
      if (n > LIMIT)
        abort_run("timed out waiting for HREADYOUT");
      @(negedge hclk);
    end
    @(posedge hclk);
    #DRIVE_DLY;
  endtask

  task automatic start_transfer(input logic wr, input logic [7:0] idx);
    hsel   = 1'b1;
    htrans = 2'b10;
    hwrite = wr;
    haddr  = addr_t'({idx, 3'b000});
    wait_ready();
    hsel   = 1'b0;
    htrans = 2'b00;
    hwrite = 1'b0;
  endtask

  task automatic write_word(input logic [7:0] idx, input data_t data, input mask_t strb);
    strobe_log[wr_cnt] = strb;
    wr_cnt = wr_cnt + 8'd1;
    ref_mem[idx] = merge_strobe(ref_mem[idx], data, strb);
    start_transfer(1'b1, idx);
    hwdata = data;
    hwstrb = strb;
    wait_ready();
  endtask

  task automatic read_word(input logic [7:0] idx);
    exp_rdata = ref_mem[idx];
    start_transfer(1'b0, idx);
    wait_ready();
  endtask

  always_ff @(posedge hclk) begin
    if (reset) begin
      dphase_q <= 1'b0;
      dwrite_q <= 1'b0;
    end else if (hreadyout) begin
      dphase_q <= hsel & htrans[1];
      dwrite_q <= hwrite;
    end
  end

  // Counts write beats taken by the controller
  always_ff @(posedge ui_clk) begin
    if (ui_rst)
      wdf_cnt <= '0;
    else if (app_wdf_wren && app_wdf_rdy)
      wdf_cnt <= wdf_cnt + 8'd1;
  end

  ////////////////////
  // Checks
  a_calib_stall: assert property (@(posedge hclk) disable iff (reset)
    (dphase_q && !calib) |-> !hreadyout)
    else report_mismatch("hreadyout before calibration", 64'd0, 64'($sampled(hreadyout)));

  a_read_data: assert property (@(posedge hclk) disable iff (reset)
    (dphase_q && !dwrite_q && hreadyout) |-> (hrdata == exp_rdata))
    else report_mismatch("read data", $sampled(exp_rdata), $sampled(hrdata));

  a_hresp_okay: assert property (@(posedge hclk) disable iff (reset) !hresp)
    else report_mismatch("hresp", 64'd0, 64'($sampled(hresp)));

  // Controller reset tracks the bus reset in and out of reset
  a_sys_reset: assert property (@(posedge hclk) sys_reset == reset)
    else report_mismatch("sys_reset", 64'($sampled(reset)), 64'($sampled(sys_reset)));

  // Mask is the inverted strobe of the same write
  a_wdf_mask: assert property (@(posedge ui_clk) disable iff (ui_rst)
    app_wdf_wren |-> (app_wdf_mask == ~strobe_log[wdf_cnt]))
    else report_mismatch("app_wdf_mask", 64'(~$sampled(strobe_log[wdf_cnt])),
                         64'($sampled(app_wdf_mask)));

  a_wdf_cmd: assert property (@(posedge ui_clk) disable iff (ui_rst)
    app_wdf_wren |-> (app_cmd == UI_WRITE))
    else report_mismatch("app_cmd", 64'(UI_WRITE), 64'($sampled(app_cmd)));

  a_wdf_end: assert property (@(posedge ui_clk) disable iff (ui_rst)
    app_wdf_end == app_wdf_wren)
    else report_mismatch("app_wdf_end", 64'($sampled(app_wdf_wren)),
                         64'($sampled(app_wdf_end)));

  ////////////////////
  // Stimulus
  initial begin
    logic [31:0] r;
    logic [31:0] hi, lo;
    int          n;
    reset      = 1'b1;
    hsel       = 1'b0;
    haddr      = '0;
    htrans     = 2'b00;
    hwrite     = 1'b0;
    hwdata     = '0;
    hwstrb     = '0;
    wr_cnt     = '0;
    exp_rdata  = '0;
    test_name  = "reset";
    rand_state = SEED;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i]    = fill_word(i[7:0]);
      u_mem.mem[i]  = fill_word(i[7:0]);
      strobe_log[i] = '0;
    end
    repeat (16) @(posedge hclk);
    #DRIVE_DLY;
    reset = 1'b0;

    // Data phase must stall while the controller calibrates
    test_name = "calib_stall";
    write_word(8'd3, 64'h0123_4567_89ab_cdef, 8'hff);

    test_name = "full_write_read";
    read_word(8'd3);
    write_word(8'd7, 64'hfeed_face_cafe_beef, 8'hff);
    read_word(8'd7);

    test_name = "partial_write";
    write_word(8'd7, 64'h1122_3344_5566_7788, 8'b1010_0101);
    read_word(8'd7);
    write_word(8'd20, 64'h9999_aaaa_bbbb_cccc, 8'h0f);
    read_word(8'd20);

    // Small address range so reads often hit earlier writes
    test_name = "random_traffic";
    for (int k = 0; k < 40; k++) begin
      r  = next_rand();
      hi = next_rand();
      lo = next_rand();
      if (r[8])
        write_word({3'b000, r[4:0]}, {hi, lo}, r[23:16]);
      else
        read_word({3'b000, r[4:0]});
    end

    test_name = "drain";
    n = 0;
    while (wdf_cnt != wr_cnt) begin
      n++;
      if (n > LIMIT)
        abort_run("timed out waiting for UI write data");
      @(posedge hclk);
    end
    repeat (10) @(posedge hclk);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/ui_mem_model.sv
// Behavioral stand-in for the DDR controller user interface
// Raises calibration some cycles after reset and stalls ready at random
// Read data returns RD_LAT cycles after the command is accepted
// The testbench fills mem before reset ends

`timescale 1ns/100ps
`default_nettype none

module ui_mem_model import memctl_pkg::*; #(
  parameter int SEED         = 9666,
  parameter int CALIB_CYCLES = 40,
  parameter int RD_LAT       = 3
) (
  input  logic    ui_clk_i,
  input  logic    sys_rst_i,
  output logic    ui_clk_sync_rst_o,
  output logic    init_calib_complete_o,
  input  addr_t   app_addr_i,
  input  ui_cmd_e app_cmd_i,
  input  logic    app_en_i,
  output logic    app_rdy_o,
  input  data_t   app_wdf_data_i,
  input  mask_t   app_wdf_mask_i,
  input  logic    app_wdf_wren_i,
  output logic    app_wdf_rdy_o,
  output data_t   app_rd_data_o,
  output logic    app_rd_data_valid_o
);

  // 256 beats of 8 bytes, indexed by app_addr[10:3]
  data_t mem [256];

  logic        rst_s1_q;
  logic [7:0]  calib_cnt_q;
  logic [31:0] rnd_q;
  // A write command and its data beat may arrive on different cycles
  logic        wa_vld_q, wd_vld_q;
  logic [7:0]  wa_idx_q;
  data_t       wd_data_q;
  mask_t       wd_mask_q;
  // Read return pipeline
  logic [RD_LAT-1:0] rd_vld_q;
  data_t             rd_data_q [RD_LAT];

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Mask bit set keeps the old byte
  function automatic data_t masked_merge(input data_t old_w, input data_t new_w, input mask_t m);
    data_t r;
    r = old_w;
    for (int b = 0; b < 8; b++) begin
      if (!m[b])
        r[8*b +: 8] = new_w[8*b +: 8];
    end
    return r;
  endfunction

  initial begin
    rst_s1_q              = 1'b1;
    ui_clk_sync_rst_o     = 1'b1;
    init_calib_complete_o = 1'b0;
    app_rdy_o             = 1'b0;
    app_wdf_rdy_o         = 1'b0;
    wa_vld_q              = 1'b0;
    wd_vld_q              = 1'b0;
    rd_vld_q              = '0;
    for (int i = 0; i < RD_LAT; i++)
      rd_data_q[i] = '0;
  end

  assign app_rd_data_valid_o = rd_vld_q[RD_LAT-1];
  assign app_rd_data_o       = rd_data_q[RD_LAT-1];

  // Controller reset follows sys_rst through two flops
  always @(posedge ui_clk_i) begin
    rst_s1_q          <= sys_rst_i;
    ui_clk_sync_rst_o <= rst_s1_q;
  end

  ////////////////////
  // Command and data acceptance
  always @(posedge ui_clk_i) begin
    logic [31:0] rnd;
    logic        a_vld, d_vld;
    logic [7:0]  a_idx;
    data_t       d_data;
    mask_t       d_mask;
    rnd    = xorshift32(rnd_q);
    a_vld  = wa_vld_q;
    a_idx  = wa_idx_q;
    d_vld  = wd_vld_q;
    d_data = wd_data_q;
    d_mask = wd_mask_q;
    if (ui_clk_sync_rst_o) begin
      rnd_q                 <= SEED;
      calib_cnt_q           <= '0;
      init_calib_complete_o <= 1'b0;
      app_rdy_o             <= 1'b0;
      app_wdf_rdy_o         <= 1'b0;
      wa_vld_q              <= 1'b0;
      wd_vld_q              <= 1'b0;
      rd_vld_q              <= '0;
    end else begin
      rnd_q <= rnd;
      if (calib_cnt_q != CALIB_CYCLES)
        calib_cnt_q <= calib_cnt_q + 8'd1;
      init_calib_complete_o <= (calib_cnt_q == CALIB_CYCLES);
      // Ready about three cycles in four once calibrated
      app_rdy_o     <= init_calib_complete_o & (rnd[0] | rnd[7]);
      app_wdf_rdy_o <= init_calib_complete_o & (rnd[3] | rnd[11]);
      if (app_en_i && app_rdy_o && app_cmd_i == UI_WRITE) begin
        a_vld = 1'b1;
        a_idx = app_addr_i[10:3];
      end
      if (app_wdf_wren_i && app_wdf_rdy_o) begin
        d_vld  = 1'b1;
        d_data = app_wdf_data_i;
        d_mask = app_wdf_mask_i;
      end
      // Commit once both halves of the write are in
      if (a_vld && d_vld) begin
        mem[a_idx] <= masked_merge(mem[a_idx], d_data, d_mask);
        a_vld = 1'b0;
        d_vld = 1'b0;
      end
      wa_vld_q  <= a_vld;
      wa_idx_q  <= a_idx;
      wd_vld_q  <= d_vld;
      wd_data_q <= d_data;
      wd_mask_q <= d_mask;
      rd_vld_q  <= {rd_vld_q[RD_LAT-2:0], app_en_i & app_rdy_o & (app_cmd_i == UI_READ)};
      rd_data_q[0] <= mem[app_addr_i[10:3]];
      for (int i = 1; i < RD_LAT; i++)
        rd_data_q[i] <= rd_data_q[i-1];
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_clkgen.sv
// Free-running clock source for the testbench
// PERIOD_NS is the full period, first rising edge after half a period

`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
  parameter real PERIOD_NS = 40.0
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: design/mig_bridge_top.sv
// Top of the AHB-Lite to DDR UI bridge
// Bus side runs on hclk with reset_i, memory side on ui_clk
// Commands cross hclk to ui_clk, read data crosses back

`timescale 1ns/100ps
`default_nettype none

`include "memctl_defs.svh"

module mig_bridge_top import memctl_pkg::*; (
  input  logic       hclk_i,
  input  logic       reset_i,
  input  logic       hsel_i,
  input  addr_t      haddr_i,
  input  logic [1:0] htrans_i,
  input  logic       hwrite_i,
  input  logic       hready_i,
  input  data_t      hwdata_i,
  input  mask_t      hwstrb_i,
  output data_t      hrdata_o,
  output logic       hreadyout_o,
  output logic       hresp_o,
  input  logic       ui_clk_i,
  input  logic       ui_clk_sync_rst_i,
  input  logic       init_calib_complete_i,
  output logic       sys_reset_o,
  output addr_t      app_addr_o,
  output ui_cmd_e    app_cmd_o,
  output logic       app_en_o,
  input  logic       app_rdy_i,
  output data_t      app_wdf_data_o,
  output mask_t      app_wdf_mask_o,
  output logic       app_wdf_wren_o,
  output logic       app_wdf_end_o,
  input  logic       app_wdf_rdy_i,
  input  data_t      app_rd_data_i,
  input  logic       app_rd_data_valid_i
);

  // Command path from hclk to ui_clk
  cmd_word_t cmd_wdata, cmd_rdata;
  logic      cmd_enq, cmd_full, cmd_deq, cmd_valid;
  // Response path from ui_clk to hclk
  data_t     rsp_wdata, rsp_rdata;
  logic      rsp_enq, rsp_deq, rsp_valid;

  // Controller reset follows the bus reset
  assign sys_reset_o = reset_i;

  ahb_front u_front (
    .hclk_i, .reset_i, .hsel_i, .haddr_i, .htrans_i, .hwrite_i, .hready_i,
    .hwdata_i, .hwstrb_i, .hrdata_o, .hreadyout_o, .hresp_o,
    .calib_done_i (init_calib_complete_i),
    .cmd_enq_o    (cmd_enq),
    .cmd_word_o   (cmd_wdata),
    .cmd_full_i   (cmd_full),
    .rsp_valid_i  (rsp_valid),
    .rsp_data_i   (rsp_rdata),
    .rsp_deq_o    (rsp_deq)
  );

  cdc_fifo #(.WIDTH($bits(cmd_word_t)), .LG_DEPTH(`MEMCTL_CMD_LG_DEPTH)) u_cmd_fifo (
    .wclk_i (hclk_i),   .wreset_i (reset_i),           .wenq_i (cmd_enq),
    .wdata_i (cmd_wdata), .wfull_o (cmd_full),
    .rclk_i (ui_clk_i), .rreset_i (ui_clk_sync_rst_i), .rdeq_i (cmd_deq),
    .rdata_o (cmd_rdata), .rvalid_o (cmd_valid)
  );

  ui_issuer u_issuer (
    .ui_clk_i, .ui_rst_i (ui_clk_sync_rst_i),
    .cmd_valid_i (cmd_valid), .cmd_word_i (cmd_rdata), .cmd_deq_o (cmd_deq),
    .app_addr_o, .app_cmd_o, .app_en_o, .app_rdy_i,
    .app_wdf_data_o, .app_wdf_mask_o, .app_wdf_wren_o, .app_wdf_end_o, .app_wdf_rdy_i,
    .app_rd_data_i, .app_rd_data_valid_i,
    .rsp_enq_o (rsp_enq), .rsp_data_o (rsp_wdata)
  );

  // One read in flight at most, so the full flag stays low
  cdc_fifo #(.WIDTH($bits(data_t)), .LG_DEPTH(`MEMCTL_RSP_LG_DEPTH)) u_rsp_fifo (
    .wclk_i (ui_clk_i), .wreset_i (ui_clk_sync_rst_i), .wenq_i (rsp_enq),
    .wdata_i (rsp_wdata), .wfull_o (),
    .rclk_i (hclk_i),   .rreset_i (reset_i),           .rdeq_i (rsp_deq),
    .rdata_o (rsp_rdata), .rvalid_o (rsp_valid)
  );

endmodule

`default_nettype wire

// File: design/ui_issuer.sv
// UI-domain sequencer of the DDR bridge on ui_clk
// Pops one command word, drives app_en and app_wdf_wren until accepted
// Read beats from the controller go back through the response FIFO

`timescale 1ns/100ps
`default_nettype none

module ui_issuer import memctl_pkg::*; (
  input  logic       ui_clk_i,
  input  logic       ui_rst_i,
  input  logic       cmd_valid_i,
  input  cmd_word_t  cmd_word_i,
  output logic       cmd_deq_o,
  output addr_t      app_addr_o,
  output ui_cmd_e    app_cmd_o,
  output logic       app_en_o,
  input  logic       app_rdy_i,
  output data_t      app_wdf_data_o,
  output mask_t      app_wdf_mask_o,
  output logic       app_wdf_wren_o,
  output logic       app_wdf_end_o,
  input  logic       app_wdf_rdy_i,
  input  data_t      app_rd_data_i,
  input  logic       app_rd_data_valid_i,
  output logic       rsp_enq_o,
  output data_t      rsp_data_o
);

  issue_state_e state_q;
  // Command and write data are accepted independently
  logic         cmd_pend_q, wdf_pend_q;
  logic         cmd_done, wdf_done;

  assign cmd_deq_o = (state_q == IS_IDLE) & cmd_valid_i;

  // Done this cycle or already done
  assign cmd_done = ~cmd_pend_q | app_rdy_i;
  assign wdf_done = ~wdf_pend_q | app_wdf_rdy_i;

  ////////////////////
  // Command payload
  always_ff @(posedge ui_clk_i) begin
    if (cmd_deq_o) begin
      app_addr_o     <= cmd_word_i.addr;
      app_cmd_o      <= cmd_word_i.write ? UI_WRITE : UI_READ;
      app_wdf_data_o <= cmd_word_i.data;
      app_wdf_mask_o <= cmd_word_i.mask;
    end
  end

  always_ff @(posedge ui_clk_i) begin
    if (ui_rst_i) begin
      state_q    <= IS_IDLE;
      cmd_pend_q <= 1'b0;
      wdf_pend_q <= 1'b0;
    end else begin
      unique case (state_q)
        IS_IDLE: begin
          if (cmd_valid_i) begin
            state_q    <= IS_BUSY;
            cmd_pend_q <= 1'b1;
            // Reads carry no write data
            wdf_pend_q <= cmd_word_i.write;
          end
        end
        IS_BUSY: begin
          if (app_rdy_i)
            cmd_pend_q <= 1'b0;
          if (app_wdf_rdy_i)
            wdf_pend_q <= 1'b0;
          if (cmd_done && wdf_done)
            state_q <= IS_IDLE;
        end
        default: state_q <= IS_IDLE;
      endcase
    end
  end

  assign app_en_o       = cmd_pend_q;
  assign app_wdf_wren_o = wdf_pend_q;
  // Single-beat writes make every beat the last
  assign app_wdf_end_o  = wdf_pend_q;

  ////////////////////
  // Read return
  always_ff @(posedge ui_clk_i) begin
    if (ui_rst_i)
      rsp_enq_o <= 1'b0;
    else
      rsp_enq_o <= app_rd_data_valid_i;
  end

  always_ff @(posedge ui_clk_i) begin
    rsp_data_o <= app_rd_data_i;
  end

endmodule

`default_nettype wire

// File: design/ahb_front.sv
// AHB-Lite slave front end of the DDR UI bridge, hclk domain
// Writes complete in one data phase once queued
// Reads stall the bus until the response crossing returns data

`timescale 1ns/100ps
`default_nettype none

module ahb_front import memctl_pkg::*; (
  input  logic         hclk_i,
  input  logic         reset_i,
  input  logic         hsel_i,
  input  addr_t        haddr_i,
  input  logic [1:0]   htrans_i,
  input  logic         hwrite_i,
  input  logic         hready_i,
  input  data_t        hwdata_i,
  input  mask_t        hwstrb_i,
  output data_t        hrdata_o,
  output logic         hreadyout_o,
  output logic         hresp_o,
  input  logic         calib_done_i,
  output logic         cmd_enq_o,
  output cmd_word_t    cmd_word_o,
  input  logic         cmd_full_i,
  input  logic         rsp_valid_i,
  input  data_t        rsp_data_i,
  output logic         rsp_deq_o
);

  front_state_e state_q;
  addr_t        addr_q;
  // Write data phase in progress
  logic         wr_pend_q;
  // Read command already pushed for this wait
  logic         rd_sent_q;
  logic         calib_s1_q, calib_q;
  logic         start;
  logic         cmd_ok;

  // NONSEQ or SEQ with the bus ready
  assign start  = hsel_i & htrans_i[1] & hready_i;
  assign cmd_ok = calib_q & ~cmd_full_i;

  // Calibration status comes from ui_clk
  always_ff @(posedge hclk_i) begin
    if (reset_i) begin
      calib_s1_q <= 1'b0;
      calib_q    <= 1'b0;
    end else begin
      calib_s1_q <= calib_done_i;
      calib_q    <= calib_s1_q;
    end
  end

  ////////////////////
  // Address phase capture
  always_ff @(posedge hclk_i) begin
    if (start)
      addr_q <= haddr_i;
  end

  // Data lanes come straight from the data phase
  assign cmd_word_o.addr  = addr_q;
  assign cmd_word_o.data  = hwdata_i;
  assign cmd_word_o.mask  = ~hwstrb_i;
  assign cmd_word_o.write = wr_pend_q;

  ////////////////////
  // Handshake
  always_comb begin
    hreadyout_o = 1'b1;
    cmd_enq_o   = 1'b0;
    rsp_deq_o   = 1'b0;
    unique case (state_q)
      FR_IDLE: begin
        // Stall the write until it can be queued
        if (wr_pend_q) begin
          hreadyout_o = cmd_ok;
          cmd_enq_o   = cmd_ok;
        end
      end
      FR_RD_WAIT: begin
        cmd_enq_o   = ~rd_sent_q & cmd_ok;
        hreadyout_o = rsp_valid_i;
        rsp_deq_o   = rsp_valid_i;
      end
      default: ;
    endcase
  end

  assign hrdata_o = rsp_data_i;
  // No error responses
  assign hresp_o  = 1'b0;

  always_ff @(posedge hclk_i) begin
    if (reset_i) begin
      state_q   <= FR_IDLE;
      wr_pend_q <= 1'b0;
      rd_sent_q <= 1'b0;
    end else begin
      if (cmd_enq_o)
        rd_sent_q <= 1'b1;
      // Data phase ends, next address phase may start here
      if (hreadyout_o) begin
        wr_pend_q <= start & hwrite_i;
        rd_sent_q <= 1'b0;
        state_q   <= (start & ~hwrite_i) ? FR_RD_WAIT : FR_IDLE;
      end
    end
  end

  // Master must honour the read stall
  a_no_start_in_wait: assert property (@(posedge hclk_i) disable iff (reset_i)
    (state_q == FR_RD_WAIT && !rsp_valid_i) |-> !start)
    else $error("AHB transfer started during read wait");

endmodule

`default_nettype wire

// File: design/cdc_fifo.sv
// Dual-clock FIFO for moving words between hclk and ui_clk
// Gray-coded pointers cross through two-flop synchronizers
// Push with wenq_i while not full, pop with rdeq_i while valid
// rdata_o shows the head word whenever rvalid_o is high

`timescale 1ns/100ps
`default_nettype none

module cdc_fifo #(
  parameter int WIDTH    = 8,
  parameter int LG_DEPTH = 3
) (
  input  logic             wclk_i,
  input  logic             wreset_i,
  input  logic             wenq_i,
  input  logic [WIDTH-1:0] wdata_i,
  output logic             wfull_o,
  input  logic             rclk_i,
  input  logic             rreset_i,
  input  logic             rdeq_i,
  output logic [WIDTH-1:0] rdata_o,
  output logic             rvalid_o
);

  // Pointers carry one extra wrap bit
  localparam int PW = LG_DEPTH + 1;

  logic [WIDTH-1:0] mem [2**LG_DEPTH];

  logic [PW-1:0] wbin_q, wgray_q, wbin_nxt;
  logic [PW-1:0] rbin_q, rgray_q, rbin_nxt;
  // Opposite pointer after two flops in each domain
  logic [PW-1:0] rgray_w1_q, rgray_w2_q;
  logic [PW-1:0] wgray_r1_q, wgray_r2_q;

  ////////////////////
  // Write side
  assign wbin_nxt = wbin_q + PW'(1);

  always_ff @(posedge wclk_i) begin
    if (wreset_i) begin
      wbin_q  <= '0;
      wgray_q <= '0;
    end else if (wenq_i) begin
      wbin_q  <= wbin_nxt;
      wgray_q <= wbin_nxt ^ (wbin_nxt >> 1);
    end
  end

  // Storage, no reset on payload
  always_ff @(posedge wclk_i) begin
    if (wenq_i)
      mem[wbin_q[LG_DEPTH-1:0]] <= wdata_i;
  end

  always_ff @(posedge wclk_i) begin
    if (wreset_i) begin
      rgray_w1_q <= '0;
      rgray_w2_q <= '0;
    end else begin
      rgray_w1_q <= rgray_q;
      rgray_w2_q <= rgray_w1_q;
    end
  end

  // Full when the pointers differ only in the top two Gray bits
  assign wfull_o = (wgray_q == {~rgray_w2_q[PW-1:PW-2], rgray_w2_q[PW-3:0]});

  ////////////////////
  // Read side
  assign rbin_nxt = rbin_q + PW'(1);

  always_ff @(posedge rclk_i) begin
    if (rreset_i) begin
      rbin_q  <= '0;
      rgray_q <= '0;
    end else if (rdeq_i) begin
      rbin_q  <= rbin_nxt;
      rgray_q <= rbin_nxt ^ (rbin_nxt >> 1);
    end
  end

  always_ff @(posedge rclk_i) begin
    if (rreset_i) begin
      wgray_r1_q <= '0;
      wgray_r2_q <= '0;
    end else begin
      wgray_r1_q <= wgray_q;
      wgray_r2_q <= wgray_r1_q;
    end
  end

  // Not empty once the synced write pointer moves past ours
  assign rvalid_o = (rgray_q != wgray_r2_q);
  assign rdata_o  = mem[rbin_q[LG_DEPTH-1:0]];

  // Producer and consumer must respect the flags
  a_no_overflow: assert property (@(posedge wclk_i) disable iff (wreset_i)
    !(wenq_i && wfull_o))
    else $error("cdc_fifo push while full");

  a_no_underflow: assert property (@(posedge rclk_i) disable iff (rreset_i)
    !(rdeq_i && !rvalid_o))
    else $error("cdc_fifo pop while empty");

endmodule

`default_nettype wire

// File: design/memctl_pkg.sv
// Shared types for the AHB to DDR UI bridge
// Modules import this package in their header

`default_nettype none

`include "memctl_defs.svh"

package memctl_pkg;

  // Byte address, data beat and byte mask
  typedef logic [`MEMCTL_ADDR_W-1:0]   addr_t;
  typedef logic [`MEMCTL_DATA_W-1:0]   data_t;
  typedef logic [`MEMCTL_DATA_W/8-1:0] mask_t;

  // One queued command, address in the upper bits
  typedef struct packed {
    addr_t addr;
    data_t data;
    mask_t mask;
    logic  write;
  } cmd_word_t;

  // UI command codes as the controller expects them
  typedef enum logic [2:0] {UI_WRITE = 3'd0, UI_READ = 3'd1} ui_cmd_e;

  typedef enum logic {FR_IDLE, FR_RD_WAIT} front_state_e;
  typedef enum logic {IS_IDLE, IS_BUSY} issue_state_e;

endpackage

`default_nettype wire

// File: design/memctl_defs.svh
// Width and depth macros for the AHB to DDR UI bridge
// Include before the package and in any module that sizes a FIFO
// All values are in bits except the FIFO depths, which are log2

`ifndef MEMCTL_DEFS_SVH
`define MEMCTL_DEFS_SVH

////////////////////
// Bus and UI widths
// Byte address as seen on HADDR and app_addr
`define MEMCTL_ADDR_W 28
// One data beat, 8 byte lanes
`define MEMCTL_DATA_W 64

////////////////////
// Crossing depths
// Command FIFO holds up to 16 beats
`define MEMCTL_CMD_LG_DEPTH 4
// Response FIFO, only one read outstanding at a time
`define MEMCTL_RSP_LG_DEPTH 3

`endif
